/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_usb_audio -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+common
common/usb_audio_pkg.sv
rtl/sample_tick_gen.sv
audio_fifo/audio_fifo.sv
rtl/pcm_byte_packer.sv
rtl/in_packet_sequencer.sv
rtl/usb_audio_datapath_top.sv
testbench/tb_clock_gen.sv
testbench/tb_usb_audio.sv

/* audio_fifo/audio_fifo.sv */
//--------------------------------------------------------------------------
// audio_fifo
// stereo frame FIFO with registered read port, sized for block RAM
// shared by the playback and capture paths
//--------------------------------------------------------------------------

`default_nettype none

`include "usb_audio_params.svh"

module audio_fifo import usb_audio_pkg::*; (
    input  wire        clk,
    input  wire        usb_rstn,
    input  wire        i_push,          // dropped when full
    input  pcm_frame_t i_wr_data,
    input  wire        i_pop,           // ignored when empty
    output pcm_frame_t o_rd_data,       // head entry, one cycle behind pointers
    output logic       o_not_empty,
    output logic       o_not_full
);

    localparam int unsigned DEPTH = 1 << `USB_AUDIO_FIFO_AW;
    localparam int          AW    = `USB_AUDIO_FIFO_AW;

    pcm_frame_t mem [0:DEPTH-1];        // frame storage
    fifo_ptr_t  wptr;
    fifo_ptr_t  wptr_vis;               // wptr once the written word is readable
    fifo_ptr_t  rptr;
    logic       do_push;
    logic       do_pop;

    //----------------------------------------------------------------------
    // flags
    //----------------------------------------------------------------------
    // full when addresses match and wrap bits differ
    assign o_not_full  = (wptr != {~rptr[AW], rptr[AW-1:0]});
    // empty side looks at the delayed wptr so the head word is always valid
    assign o_not_empty = (wptr_vis != rptr);

    assign do_push = i_push & o_not_full;
    assign do_pop  = i_pop & o_not_empty;

    //----------------------------------------------------------------------
    // pointers
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            wptr     <= '0;
            wptr_vis <= '0;
            rptr     <= '0;
        end else begin
            wptr_vis <= wptr;                       // trails by one clk
            if (do_push)
                wptr <= wptr + fifo_ptr_t'(1);
            if (do_pop)
                rptr <= rptr + fifo_ptr_t'(1);
        end
    end

    //----------------------------------------------------------------------
    // storage, write and registered read
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wptr[AW-1:0]] <= i_wr_data;
    end

    always_ff @(posedge clk) begin
        o_rd_data <= mem[rptr[AW-1:0]];             // plain sync read, maps to BRAM
    end

    // occupancy never goes past the array size
    a_ptr_dist: assert property (@(posedge clk) disable iff (!usb_rstn)
        fifo_ptr_t'(wptr - rptr) <= fifo_ptr_t'(DEPTH));

endmodule

`default_nettype wire

/* common/usb_audio_params.svh */
//--------------------------------------------------------------------------
// USB audio data path constants
// sample divider, FIFO sizing and isochronous packet geometry
//--------------------------------------------------------------------------

`ifndef USB_AUDIO_PARAMS_SVH
`define USB_AUDIO_PARAMS_SVH

//--------------------------------------------------------------------------
// timing
//--------------------------------------------------------------------------
// 60 MHz / 48 kHz, clk cycles per stereo sample
`define USB_AUDIO_SAMPLE_DIV 1250

//--------------------------------------------------------------------------
// buffering
//--------------------------------------------------------------------------
// FIFO address bits, 2**9 = 512 stereo frames per direction
`define USB_AUDIO_FIFO_AW 9

//--------------------------------------------------------------------------
// packet geometry
//--------------------------------------------------------------------------
// stereo frames carried in one 1 ms IN packet
`define USB_AUDIO_PKT_FRAMES 48
// L lo, L hi, R lo, R hi
`define USB_AUDIO_FRAME_BYTES 4

`endif

/* common/usb_audio_pkg.sv */
//--------------------------------------------------------------------------
// USB audio shared types
// byte, sample and frame vectors plus the IN sequencer state encoding
//--------------------------------------------------------------------------

`default_nettype none

`include "usb_audio_params.svh"

package usb_audio_pkg;

    // endpoint byte, both OUT and IN directions
    typedef logic [7:0] usb_byte_t;

    // one signed PCM channel sample
    typedef logic signed [15:0] pcm_sample_t;

    // stereo frame = {right[15:0], left[15:0]}
    typedef logic [31:0] pcm_frame_t;

    // FIFO pointer, address bits plus wrap bit on top
    typedef logic [`USB_AUDIO_FIFO_AW:0] fifo_ptr_t;

    // IN packet sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // waiting for start-of-frame
        FETCH = 2'd1,   // head frame settling on the FIFO read port
        SEND  = 2'd2    // streaming the 4 bytes of the current frame
    } in_seq_state_t;

endpackage

`default_nettype wire

/* rtl/in_packet_sequencer.sv */
//--------------------------------------------------------------------------
// in_packet_sequencer
// after each start-of-frame, pops capture frames and serializes them
// into one 192-byte isochronous IN packet, zero-filling when dry
//--------------------------------------------------------------------------

`default_nettype none

`include "usb_audio_params.svh"

module in_packet_sequencer import usb_audio_pkg::*; (
    input  wire        clk,
    input  wire        usb_rstn,
    input  wire        i_sof,           // starts or restarts a packet
    input  pcm_frame_t i_frame,         // capture FIFO head
    input  wire        i_frame_avail,   // capture FIFO not empty
    output logic       o_pop,
    output usb_byte_t  o_data,
    output logic       o_valid,
    input  wire        i_ready
);

    localparam logic [1:0] LAST_BYTE  = 2'(`USB_AUDIO_FRAME_BYTES - 1);
    localparam logic [5:0] LAST_FRAME = 6'(`USB_AUDIO_PKT_FRAMES - 1);

    in_seq_state_t state;
    logic [1:0]    byte_cnt;            // byte within frame, LL LH RL RH
    logic [5:0]    frame_cnt;           // frame within packet
    logic          have_frame;          // FIFO had data at FETCH
    logic          hs;                  // byte handshake
    logic          last_byte;

    //----------------------------------------------------------------------
    // byte stream
    //----------------------------------------------------------------------
    assign o_valid   = (state == SEND);
    assign hs        = o_valid & i_ready;
    assign last_byte = (byte_cnt == LAST_BYTE);
    // frame is consumed only once its 4th byte has gone out
    assign o_pop     = hs & last_byte & have_frame;
    // zero bytes stand in for a missing frame
    assign o_data    = have_frame ? i_frame[{byte_cnt, 3'b000} +: 8] : '0;

    //----------------------------------------------------------------------
    // FSM
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            state      <= IDLE;
            byte_cnt   <= '0;
            frame_cnt  <= '0;
            have_frame <= 1'b0;
        end else if (i_sof) begin
            state     <= FETCH;                     // restart, even mid-packet
            byte_cnt  <= '0;
            frame_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    state <= IDLE;                  // wait for next sof
                end
                FETCH: begin
                    have_frame <= i_frame_avail;    // read port settles this cycle
                    state      <= SEND;
                end
                SEND: begin
                    if (hs) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (last_byte) begin
                            if (frame_cnt == LAST_FRAME) begin
                                state <= IDLE;      // 192nd byte accepted
                            end else begin
                                frame_cnt <= frame_cnt + 6'd1;
                                state     <= FETCH;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // checks
    //----------------------------------------------------------------------
    // a stalled byte stays offered unchanged until taken
    a_hold_stable: assert property (@(posedge clk) disable iff (!usb_rstn)
        o_valid && !i_ready && !i_sof |=> state == SEND && $stable(o_data));

    // pop only on a handshake and never into an empty capture FIFO
    a_pop_legal: assert property (@(posedge clk) disable iff (!usb_rstn)
        o_pop |-> hs && i_frame_avail);

endmodule

`default_nettype wire

/* rtl/pcm_byte_packer.sv */
//--------------------------------------------------------------------------
// pcm_byte_packer
// packs little-endian OUT endpoint bytes into 32-bit stereo frames
// start-of-frame realigns the byte counter
//--------------------------------------------------------------------------

`default_nettype none

`include "usb_audio_params.svh"

module pcm_byte_packer import usb_audio_pkg::*; (
    input  wire        clk,
    input  wire        usb_rstn,
    input  wire        i_sof,           // new USB frame, drops a partial PCM frame
    input  usb_byte_t  i_data,
    input  wire        i_valid,         // one byte per valid cycle
    output pcm_frame_t o_frame,         // {right, left}
    output logic       o_frame_valid    // one clk, after the 4th byte
);

    localparam logic [1:0] LAST_BYTE = 2'(`USB_AUDIO_FRAME_BYTES - 1);

    logic [1:0] byte_cnt;               // position within current frame

    // control, counter and strobe
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            byte_cnt      <= '0;
            o_frame_valid <= 1'b0;
        end else begin
            o_frame_valid <= 1'b0;
            if (i_sof) begin
                byte_cnt <= '0;                     // throw away partial frame
            end else if (i_valid) begin
                byte_cnt      <= byte_cnt + 2'd1;
                o_frame_valid <= (byte_cnt == LAST_BYTE);
            end
        end
    end

    // payload, bytes enter at the top and move toward bit 0
    always_ff @(posedge clk) begin
        if (i_valid && !i_sof)
            o_frame <= {i_data, o_frame[31:8]};     // 1st byte ends up in [7:0]
    end

endmodule

`default_nettype wire

/* rtl/sample_tick_gen.sv */
//--------------------------------------------------------------------------
// sample_tick_gen
// divides clk down to a one-cycle 48 kHz audio sample strobe
//--------------------------------------------------------------------------

`default_nettype none

`include "usb_audio_params.svh"

module sample_tick_gen (
    input  wire  clk,
    input  wire  usb_rstn,
    output logic o_tick                 // one clk wide, once per sample period
);

    localparam logic [10:0] DIV_LAST = 11'(`USB_AUDIO_SAMPLE_DIV - 1);

    logic [10:0] cnt;                   // 0 .. DIV-1

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (cnt == DIV_LAST) begin
            cnt    <= '0;               // wrap, strobe lands exactly DIV cycles apart
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt + 11'd1;
            o_tick <= 1'b0;
        end
    end

    // counter must stay inside one sample period
    a_cnt_range: assert property (@(posedge clk) disable iff (!usb_rstn)
        cnt < 11'(`USB_AUDIO_SAMPLE_DIV));

endmodule

`default_nettype wire

/* rtl/usb_audio_datapath_top.sv */
//--------------------------------------------------------------------------
// usb_audio_datapath_top
// audio data path between the USB core endpoints and the codec side
// playback OUT bytes -> FIFO -> 48 kHz, capture 48 kHz -> FIFO -> IN
//--------------------------------------------------------------------------

`default_nettype none

module usb_audio_datapath_top import usb_audio_pkg::*; (
    input  wire         clk,            // 60 MHz
    input  wire         usb_rstn,
    input  wire         i_sof,          // 1 ms start-of-frame strobe
    // OUT endpoint, host to device
    input  usb_byte_t   i_out_data,
    input  wire         i_out_valid,
    // IN endpoint, device to host
    output usb_byte_t   o_in_data,
    output logic        o_in_valid,
    input  wire         i_in_ready,
    // playback side
    output logic        o_audio_en,     // 48 kHz strobe
    output pcm_sample_t o_audio_l,      // valid one clk after o_audio_en
    output pcm_sample_t o_audio_r,
    // capture side, sampled on o_audio_en
    input  pcm_sample_t i_audio_l,
    input  pcm_sample_t i_audio_r
);

    logic       tick;

    pcm_frame_t pk_frame;               // packer -> playback FIFO
    logic       pk_frame_valid;
    logic       play_push;
    logic       play_pop;
    pcm_frame_t play_rd;
    logic       play_not_empty;
    logic       play_not_full;

    logic       cap_push;
    pcm_frame_t cap_wr;
    logic       cap_pop;
    pcm_frame_t cap_rd;
    logic       cap_not_empty;
    logic       cap_not_full;

    //----------------------------------------------------------------------
    // sample timing
    //----------------------------------------------------------------------
    sample_tick_gen u_tick (
        .clk      (clk),
        .usb_rstn (usb_rstn),
        .o_tick   (tick)
    );

    assign o_audio_en = tick;

    //----------------------------------------------------------------------
    // playback path
    //----------------------------------------------------------------------
    pcm_byte_packer u_packer (
        .clk           (clk),
        .usb_rstn      (usb_rstn),
        .i_sof         (i_sof),
        .i_data        (i_out_data),
        .i_valid       (i_out_valid),
        .o_frame       (pk_frame),
        .o_frame_valid (pk_frame_valid)
    );

    assign play_push = pk_frame_valid & play_not_full;  // overflow drops the frame
    assign play_pop  = tick & play_not_empty;           // one frame per sample

    audio_fifo play_fifo (
        .clk         (clk),
        .usb_rstn    (usb_rstn),
        .i_push      (play_push),
        .i_wr_data   (pk_frame),
        .i_pop       (play_pop),
        .o_rd_data   (play_rd),
        .o_not_empty (play_not_empty),
        .o_not_full  (play_not_full)
    );

    // output regs, hold last sample on underrun
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            o_audio_l <= '0;
            o_audio_r <= '0;
        end else if (play_pop) begin
            o_audio_l <= pcm_sample_t'(play_rd[15:0]);
            o_audio_r <= pcm_sample_t'(play_rd[31:16]);
        end
    end

    //----------------------------------------------------------------------
    // capture path
    //----------------------------------------------------------------------
    assign cap_wr   = {i_audio_r, i_audio_l};
    assign cap_push = tick & cap_not_full;              // mic sampled on tick itself

    audio_fifo cap_fifo (
        .clk         (clk),
        .usb_rstn    (usb_rstn),
        .i_push      (cap_push),
        .i_wr_data   (cap_wr),
        .i_pop       (cap_pop),
        .o_rd_data   (cap_rd),
        .o_not_empty (cap_not_empty),
        .o_not_full  (cap_not_full)
    );

    in_packet_sequencer u_in_seq (
        .clk           (clk),
        .usb_rstn      (usb_rstn),
        .i_sof         (i_sof),
        .i_frame       (cap_rd),
        .i_frame_avail (cap_not_empty),
        .o_pop         (cap_pop),
        .o_data        (o_in_data),
        .o_valid       (o_in_valid),
        .i_ready       (i_in_ready)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
//--------------------------------------------------------------------------
// tb_clock_gen
// testbench clock, period 4, and active-low reset held for 8 cycles
//--------------------------------------------------------------------------

`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic usb_rstn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 time units per cycle
    end

    initial begin
        usb_rstn = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        usb_rstn = 1'b1;                // release away from the active edge
    end

endmodule

`default_nettype wire

/* testbench/tb_usb_audio.sv */
//--------------------------------------------------------------------------
// tb_usb_audio
// table-driven testbench for the USB audio data path that checks playback
// order and hold, capture packets with random IN ready and packet restart
//--------------------------------------------------------------------------

`default_nettype none

`include "usb_audio_params.svh"

module tb_usb_audio import usb_audio_pkg::*;;

    localparam int TBL_LEN  = 12;
    localparam int DIV      = `USB_AUDIO_SAMPLE_DIV;
    localparam int PKT_LEN  = `USB_AUDIO_PKT_FRAMES * `USB_AUDIO_FRAME_BYTES;
    localparam int WATCHDOG = (TBL_LEN + 4) * DIV * 4 + 20000;

    typedef struct packed {
        logic [31:0] out_frame;         // {right, left} sent as OUT bytes
        logic        partial;           // sof after 2 bytes drops the frame
        logic [15:0] mic_l;
        logic [15:0] mic_r;
    } stim_t;

    logic        clk;
    logic        usb_rstn;
    logic        i_sof;
    usb_byte_t   i_out_data;
    logic        i_out_valid;
    usb_byte_t   o_in_data;
    logic        o_in_valid;
    logic        i_in_ready;
    logic        o_audio_en;
    pcm_sample_t o_audio_l;
    pcm_sample_t o_audio_r;
    pcm_sample_t i_audio_l;
    pcm_sample_t i_audio_r;

    stim_t       tbl [TBL_LEN];
    logic [31:0] exp_play [TBL_LEN];    // complete frames in send order
    int          exp_play_n = 0;
    int          play_rd = 0;
    logic [31:0] cur_play = '0;         // value the playback regs should show
    logic        play_pending = 1'b0;
    logic [31:0] cap_q [$];             // model of the capture FIFO
    int          cyc = 0;
    int          last_tick = 0;
    int          byte_idx = 0;
    logic        frame_present = 1'b0;
    int          pkt_bytes = 0;
    int          sof_req = 0;
    int          sof_ack = 0;
    logic [31:0] lfsr = 32'h804f3f70;

    tb_clock_gen u_clk (
        .clk      (clk),
        .usb_rstn (usb_rstn)
    );

    usb_audio_datapath_top UUT (
        .clk         (clk),
        .usb_rstn    (usb_rstn),
        .i_sof       (i_sof),
        .i_out_data  (i_out_data),
        .i_out_valid (i_out_valid),
        .o_in_data   (o_in_data),
        .o_in_valid  (o_in_valid),
        .i_in_ready  (i_in_ready),
        .o_audio_en  (o_audio_en),
        .o_audio_l   (o_audio_l),
        .o_audio_r   (o_audio_r),
        .i_audio_l   (i_audio_l),
        .i_audio_r   (i_audio_r)
    );

    //----------------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------------
    // right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic fail_check(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic send_byte(input usb_byte_t b);
        @(negedge clk);
        i_out_data  = b;
        i_out_valid = 1'b1;
    endtask

    task automatic send_idle();
        @(negedge clk);
        i_out_valid = 1'b0;
        i_out_data  = '0;
    endtask

    // monitor raises i_sof on the negedge after the request
    task automatic request_sof();
        @(posedge clk);
        sof_req = sof_req + 1;
        @(negedge clk);
        @(posedge clk);
    endtask

    task automatic wait_tick();
        int t;
        t = 0;
        @(negedge clk);
        while (!o_audio_en) begin
            @(negedge clk);
            t++;
            if (t > 2 * DIV)
                fail_check("no sample tick seen within two sample periods");
        end
    endtask

    task automatic wait_bytes(input int n);
        int t;
        t = 0;
        while (pkt_bytes < n) begin
            @(posedge clk);
            t++;
            if (t > 4000)
                fail_check("IN packet stalled, byte count stopped growing");
        end
    endtask

    task automatic run_packet(input int restart_at);
        request_sof();
        if (restart_at > 0) begin
            wait_bytes(restart_at);
            request_sof();                  // restart mid-packet
        end
        wait_bytes(PKT_LEN);
        repeat (20) @(negedge clk);
        assert (pkt_bytes == PKT_LEN) else
            fail_check($sformatf("packet has %0d bytes, expected %0d", pkt_bytes, PKT_LEN));
        assert (!o_in_valid) else
            fail_check("o_in_valid still high after the last packet byte");
    endtask

    task automatic load_table();
        tbl[0]  = '{32'hfff1_0010, 1'b0, 16'h0101, 16'hf101};
        tbl[1]  = '{32'h7fff_8000, 1'b0, 16'h0202, 16'hf202};
        tbl[2]  = '{32'h1234_5678, 1'b0, 16'h0303, 16'hf303};
        tbl[3]  = '{32'hdead_beef, 1'b1, 16'h0404, 16'hf404};
        tbl[4]  = '{32'h0a0b_0c0d, 1'b0, 16'h0505, 16'hf505};
        tbl[5]  = '{32'h8001_7ffe, 1'b0, 16'h0606, 16'hf606};
        tbl[6]  = '{32'h5a5a_a5a5, 1'b0, 16'h8007, 16'h7ff7};
        tbl[7]  = '{32'h0000_ffff, 1'b0, 16'h0808, 16'hf808};
        tbl[8]  = '{32'hc3c3_3c3c, 1'b0, 16'h0909, 16'hf909};
        tbl[9]  = '{32'h2468_1357, 1'b0, 16'h0a0a, 16'hfa0a};
        tbl[10] = '{32'h0001_0002, 1'b0, 16'h0b0b, 16'hfb0b};
        tbl[11] = '{32'h9876_5432, 1'b0, 16'h0c0c, 16'hfc0c};
    endtask

    //----------------------------------------------------------------------
    // cycle count since reset release
    //----------------------------------------------------------------------
    always @(posedge clk) begin
        if (usb_rstn)
            cyc <= cyc + 1;
    end

    //----------------------------------------------------------------------
    // monitor for ticks, playback, capture model, IN ready and sof
    //----------------------------------------------------------------------
    initial begin
        logic rdy;
        logic [7:0] exp_b;
        i_sof      = 1'b0;
        i_in_ready = 1'b0;
        wait (usb_rstn);                    // first monitored edge follows release
        forever begin
            @(negedge clk);
            if (play_pending) begin             // outputs move one clk after tick
                assert (o_audio_l == cur_play[15:0] && o_audio_r == cur_play[31:16]) else
                    fail_check($sformatf("playback L/R %h/%h, expected %h/%h",
                        o_audio_l, o_audio_r, cur_play[15:0], cur_play[31:16]));
                play_pending = 1'b0;
            end
            if (o_audio_en) begin
                assert (cyc - last_tick == DIV) else
                    fail_check($sformatf("tick spacing %0d cycles", cyc - last_tick));
                last_tick = cyc;
                if (play_rd < exp_play_n) begin
                    cur_play = exp_play[play_rd];
                    play_rd++;
                end
                play_pending = 1'b1;
                cap_q.push_back({i_audio_r, i_audio_l});
            end
            rdy        = lfsr[0];
            lfsr       = galois_step(lfsr);
            i_in_ready = rdy;
            if (o_in_valid && rdy) begin
                if (byte_idx == 0)
                    frame_present = (cap_q.size() > 0);
                exp_b = frame_present ? cap_q[0][8*byte_idx +: 8] : 8'h00;
                assert (o_in_data == exp_b) else
                    fail_check($sformatf("IN byte %0d is %h, expected %h",
                        pkt_bytes, o_in_data, exp_b));
                pkt_bytes++;
                if (byte_idx == 3) begin
                    if (frame_present)
                        void'(cap_q.pop_front());
                    byte_idx = 0;
                end else begin
                    byte_idx++;
                end
            end
            if (sof_ack != sof_req) begin
                i_sof     = 1'b1;
                sof_ack   = sof_req;
                byte_idx  = 0;                  // packet restarts from frame 0
                pkt_bytes = 0;
            end else begin
                i_sof = 1'b0;
            end
        end
    end

    //----------------------------------------------------------------------
    // watchdog
    //----------------------------------------------------------------------
    initial begin
        #(WATCHDOG);
        $display("TIMEOUT: simulation ran past %0d time units", WATCHDOG);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial begin
        i_out_data  = '0;
        i_out_valid = 1'b0;
        i_audio_l   = '0;
        i_audio_r   = '0;
        load_table();
        wait (usb_rstn);
        @(negedge clk);
        assert (!o_in_valid && !o_audio_en && o_audio_l == 0 && o_audio_r == 0) else
            fail_check("outputs not idle after reset");

        // all OUT frames queued ahead of the first tick
        for (int i = 0; i < TBL_LEN; i++) begin
            if (tbl[i].partial) begin
                send_byte(tbl[i].out_frame[7:0]);
                send_byte(tbl[i].out_frame[15:8]);
                send_idle();
                request_sof();                      // partial frame thrown away
            end else begin
                for (int k = 0; k < 4; k++)
                    send_byte(tbl[i].out_frame[8*k +: 8]);
                exp_play[exp_play_n] = tbl[i].out_frame;
                exp_play_n++;
            end
        end
        send_idle();

        // capture one table entry per tick
        i_audio_l = pcm_sample_t'(tbl[0].mic_l);
        i_audio_r = pcm_sample_t'(tbl[0].mic_r);
        for (int i = 0; i < TBL_LEN; i++) begin
            wait_tick();
            @(negedge clk);
            if (i + 1 < TBL_LEN) begin
                i_audio_l = pcm_sample_t'(tbl[i+1].mic_l);
                i_audio_r = pcm_sample_t'(tbl[i+1].mic_r);
            end
            if (i == 5)
                run_packet(0);                      // 6 frames then zero fill
            if (i == TBL_LEN - 1)
                run_packet(10);                     // restart after 10 bytes
        end

        // playback FIFO dry so the outputs must hold
        wait_tick();
        wait_tick();
        repeat (4) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
